//--- logic/gcd_pkg.sv
// shared widths, queue depths and encodings for the GCD accelerator
// RTL files refer to these by scoped names, gcd_pkg::name
`default_nettype none

package gcd_pkg;

  // -------------------------------------------------------------------
  // widths and depths
  // -------------------------------------------------------------------

  // one operand, also the result width
  localparam int OPERAND_WIDTH = 16;

  // request message carries a in the upper half, b in the lower half
  localparam int REQ_WIDTH = 2 * OPERAND_WIDTH;

  // queue entries, must be powers of two
  localparam int REQ_QUEUE_DEPTH  = 2;
  localparam int RESP_QUEUE_DEPTH = 2;

  typedef logic [OPERAND_WIDTH-1:0] operand_t;

  // -------------------------------------------------------------------
  // control encodings
  // -------------------------------------------------------------------

  typedef enum logic [1:0] {
    STATE_IDLE = 2'd0,
    STATE_CALC = 2'd1,
    STATE_DONE = 2'd2
  } gcd_state_e;

  // a register source
  typedef enum logic [1:0] {
    A_SEL_IN  = 2'd0,
    A_SEL_SUB = 2'd1,
    A_SEL_B   = 2'd2
  } a_sel_e;

  // b register source
  typedef enum logic {
    B_SEL_IN = 1'b0,
    B_SEL_A  = 1'b1
  } b_sel_e;

endpackage

`default_nettype wire

//--- logic/msg_queue.sv
// single-clock valid/ready queue, power-of-two depth
// used in front of and behind the GCD unit; one instance per width
`timescale 1ns/1ps
`default_nettype none

module msg_queue #(
  parameter int WIDTH = gcd_pkg::OPERAND_WIDTH,
  parameter int DEPTH = gcd_pkg::RESP_QUEUE_DEPTH
) (
  input  wire             clk,
  input  wire             reset,
  input  wire             enq_val,
  output logic            enq_rdy,
  input  wire [WIDTH-1:0] enq_msg,
  output logic            deq_val,
  input  wire             deq_rdy,
  output logic [WIDTH-1:0] deq_msg
);

  // address bits, pointers carry one more as the wrap bit
  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // wrap-bit compare only works for power-of-two depths
  if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
    $error("msg_queue DEPTH must be a power of two and at least 2");
  end

  // -------------------------------------------------------------------
  // pointers and status
  // -------------------------------------------------------------------

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] rd_ptr;
  logic                enq_go;
  logic                deq_go;
  logic                full;
  logic                empty;

  // transfers on both sides
  assign enq_go = enq_val && enq_rdy;
  assign deq_go = deq_val && deq_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (enq_go) begin
      wr_ptr <= wr_ptr + (ADDR_WIDTH + 1)'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (deq_go) begin
      rd_ptr <= rd_ptr + (ADDR_WIDTH + 1)'(1);
    end
  end

  // same slot, opposite lap: writer is a full lap ahead
  assign full = (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0])
             && (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]);

  // identical pointers incl. wrap bit
  assign empty = (wr_ptr == rd_ptr);

  // ready from state only, never from enq_val
  assign enq_rdy = !full;
  assign deq_val = !empty;

  // -------------------------------------------------------------------
  // storage
  // -------------------------------------------------------------------

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (enq_go) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= enq_msg;
    end
  end

  // head entry, read combinationally
  assign deq_msg = mem[rd_ptr[ADDR_WIDTH-1:0]];

endmodule

`default_nettype wire

//--- logic/gcd_ctrl.sv
// control FSM for the GCD unit, idle / calc / done
// drives datapath selects and enables from the a<b and b==0 status
`timescale 1ns/1ps
`default_nettype none

module gcd_ctrl (
  input  wire               clk,
  input  wire               reset,
  input  wire               in_val,
  output logic              in_rdy,
  output logic              out_val,
  input  wire               out_rdy,
  input  wire               is_a_lt_b,
  input  wire               is_b_zero,
  output gcd_pkg::a_sel_e   a_sel,
  output logic              a_en,
  output gcd_pkg::b_sel_e   b_sel,
  output logic              b_en
);

  gcd_pkg::gcd_state_e state;
  gcd_pkg::gcd_state_e state_next;

  // one calc step is either a swap or a subtract
  logic do_swap;
  logic do_sub;

  assign do_swap = is_a_lt_b;
  assign do_sub  = !is_a_lt_b && !is_b_zero;

  // -------------------------------------------------------------------
  // state register and transitions
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= gcd_pkg::STATE_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      gcd_pkg::STATE_IDLE: begin
        // operands taken this edge
        if (in_val && in_rdy) begin
          state_next = gcd_pkg::STATE_CALC;
        end
      end
      gcd_pkg::STATE_CALC: begin
        // a >= b and b == 0 leaves the gcd in a
        if (!is_a_lt_b && is_b_zero) begin
          state_next = gcd_pkg::STATE_DONE;
        end
      end
      gcd_pkg::STATE_DONE: begin
        // hold here while the response queue is full
        if (out_val && out_rdy) begin
          state_next = gcd_pkg::STATE_IDLE;
        end
      end
      default: begin
        state_next = gcd_pkg::STATE_IDLE;
      end
    endcase
  end

  // -------------------------------------------------------------------
  // outputs
  // -------------------------------------------------------------------

  always_comb begin
    // done values, selects are don't-care there
    in_rdy  = 1'b0;
    out_val = 1'b0;
    a_sel   = gcd_pkg::A_SEL_IN;
    a_en    = 1'b0;
    b_sel   = gcd_pkg::B_SEL_IN;
    b_en    = 1'b0;
    case (state)
      gcd_pkg::STATE_IDLE: begin
        in_rdy = 1'b1;
        // load both registers on the request transfer
        a_en   = in_val;
        b_en   = in_val;
      end
      gcd_pkg::STATE_CALC: begin
        // swap moves b into a and a into b
        a_sel = do_swap ? gcd_pkg::A_SEL_B : gcd_pkg::A_SEL_SUB;
        a_en  = do_swap || do_sub;
        b_sel = gcd_pkg::B_SEL_A;
        b_en  = do_swap;
      end
      gcd_pkg::STATE_DONE: begin
        out_val = 1'b1;
      end
      default: begin
        in_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/gcd_dpath.sv
// GCD datapath, operand registers with input muxes
// subtractor plus less-than and zero status back to control
`timescale 1ns/1ps
`default_nettype none

module gcd_dpath (
  input  wire                             clk,
  input  wire [gcd_pkg::REQ_WIDTH-1:0]    in_msg,
  input  wire gcd_pkg::a_sel_e            a_sel,
  input  wire                             a_en,
  input  wire gcd_pkg::b_sel_e            b_sel,
  input  wire                             b_en,
  output logic                            is_a_lt_b,
  output logic                            is_b_zero,
  output gcd_pkg::operand_t               result
);

  // request halves
  gcd_pkg::operand_t in_a;
  gcd_pkg::operand_t in_b;

  assign in_a = in_msg[gcd_pkg::REQ_WIDTH-1 -: gcd_pkg::OPERAND_WIDTH];
  assign in_b = in_msg[gcd_pkg::OPERAND_WIDTH-1:0];

  gcd_pkg::operand_t a_reg;
  gcd_pkg::operand_t b_reg;
  gcd_pkg::operand_t a_next;
  gcd_pkg::operand_t b_next;
  gcd_pkg::operand_t diff;

  // -------------------------------------------------------------------
  // input muxes
  // -------------------------------------------------------------------

  // three-way for a
  always_comb begin
    case (a_sel)
      gcd_pkg::A_SEL_IN:  a_next = in_a;
      gcd_pkg::A_SEL_SUB: a_next = diff;
      gcd_pkg::A_SEL_B:   a_next = b_reg;
      default:            a_next = in_a;
    endcase
  end

  // two-way for b
  always_comb begin
    case (b_sel)
      gcd_pkg::B_SEL_IN: b_next = in_b;
      gcd_pkg::B_SEL_A:  b_next = a_reg;
      default:           b_next = in_b;
    endcase
  end

  // -------------------------------------------------------------------
  // operand registers
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      b_reg <= b_next;
    end
  end

  // -------------------------------------------------------------------
  // arithmetic and status
  // -------------------------------------------------------------------

  // only used when a >= b, so no borrow
  assign diff = a_reg - b_reg;

  assign is_a_lt_b = (a_reg < b_reg);
  assign is_b_zero = (b_reg == '0);

  // in done b is zero, so a - b is just a
  assign result = diff;

endmodule

`default_nettype wire

//--- logic/gcd_top.sv
// GCD accelerator top level
// request queue -> control + datapath -> response queue, one clock
`timescale 1ns/1ps
`default_nettype none

module gcd_top (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           req_val,
  output wire                           req_rdy,
  input  wire [gcd_pkg::REQ_WIDTH-1:0]  req_msg,
  output wire                           resp_val,
  input  wire                           resp_rdy,
  output wire gcd_pkg::operand_t        resp_msg
);

  // -------------------------------------------------------------------
  // internal wires
  // -------------------------------------------------------------------

  // request queue to unit
  wire                          in_val;
  wire                          in_rdy;
  wire [gcd_pkg::REQ_WIDTH-1:0] in_msg;

  // unit to response queue
  wire                          out_val;
  wire                          out_rdy;
  wire gcd_pkg::operand_t       result;

  // control to datapath
  wire gcd_pkg::a_sel_e         a_sel;
  wire                          a_en;
  wire gcd_pkg::b_sel_e         b_sel;
  wire                          b_en;

  // datapath status back
  wire                          is_a_lt_b;
  wire                          is_b_zero;

  // -------------------------------------------------------------------
  // request side
  // -------------------------------------------------------------------

  msg_queue #(
    .WIDTH (gcd_pkg::REQ_WIDTH),
    .DEPTH (gcd_pkg::REQ_QUEUE_DEPTH)
  ) req_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .enq_msg (req_msg),
    .deq_val (in_val),
    .deq_rdy (in_rdy),
    .deq_msg (in_msg)
  );

  // -------------------------------------------------------------------
  // compute unit
  // -------------------------------------------------------------------

  gcd_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .is_a_lt_b (is_a_lt_b),
    .is_b_zero (is_b_zero),
    .a_sel     (a_sel),
    .a_en      (a_en),
    .b_sel     (b_sel),
    .b_en      (b_en)
  );

  // operands straight from the queue head
  gcd_dpath dpath (
    .clk       (clk),
    .in_msg    (in_msg),
    .a_sel     (a_sel),
    .a_en      (a_en),
    .b_sel     (b_sel),
    .b_en      (b_en),
    .is_a_lt_b (is_a_lt_b),
    .is_b_zero (is_b_zero),
    .result    (result)
  );

  // -------------------------------------------------------------------
  // response side
  // -------------------------------------------------------------------

  // drained by the outside consumer
  msg_queue #(
    .WIDTH (gcd_pkg::OPERAND_WIDTH),
    .DEPTH (gcd_pkg::RESP_QUEUE_DEPTH)
  ) resp_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (out_val),
    .enq_rdy (out_rdy),
    .enq_msg (result),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy),
    .deq_msg (resp_msg)
  );

endmodule

`default_nettype wire

//--- test/gcd_top_properties.sv
// concurrent checks on the GCD accelerator handshakes and reset state
// bound into every gcd_top instance, failures counted in error_count
`timescale 1ns/1ps
`default_nettype none

module gcd_top_properties (
  input wire                          clk,
  input wire                          reset,
  input wire                          req_val,
  input wire                          req_rdy,
  input wire [gcd_pkg::REQ_WIDTH-1:0] req_msg,
  input wire                          resp_val,
  input wire                          resp_rdy,
  input wire gcd_pkg::operand_t       resp_msg
);

  // read by the testbench for its verdict
  int unsigned error_count = 0;

  // accepted requests minus delivered responses
  int   in_flight;
  logic seen_req;

  always @(posedge clk) begin
    if (reset) begin
      in_flight <= 0;
      seen_req  <= 1'b0;
    end else begin
      in_flight <= in_flight + int'(req_val && req_rdy) - int'(resp_val && resp_rdy);
      if (req_val && req_rdy) begin
        seen_req <= 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------
  // handshake stability
  // -------------------------------------------------------------------

  // response held while the consumer stalls
  resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else begin error_count++; $error("resp_val or resp_msg changed while stalled"); end

  // guards the request driver
  req_stable: assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val && $stable(req_msg))
    else begin error_count++; $error("req_val or req_msg changed while stalled"); end

  // -------------------------------------------------------------------
  // occupancy and reset
  // -------------------------------------------------------------------

  // two queues of two plus the one in the unit
  occupancy: assert property (@(posedge clk) disable iff (reset)
    in_flight <= gcd_pkg::REQ_QUEUE_DEPTH + gcd_pkg::RESP_QUEUE_DEPTH + 1)
    else begin error_count++; $error("more requests in flight than storage allows"); end

  // first cycle out of reset
  reset_state: assert property (@(posedge clk) $fell(reset) |-> req_rdy && !resp_val)
    else begin error_count++; $error("wrong handshake state after reset"); end

  // no response out of nothing
  no_early_resp: assert property (@(posedge clk) disable iff (reset) !seen_req |-> !resp_val)
    else begin error_count++; $error("resp_val rose before any request"); end

endmodule

bind gcd_top gcd_top_properties props (.*);

`default_nettype wire

//--- test/gcd_top_tb.sv
// testbench for the GCD accelerator top level
// directed, random, back-pressure, occupancy and reset tests
// values checked against a Euclid reference and handshakes by bound properties
`timescale 1ns/1ps
`default_nettype none

module gcd_top_tb;

  localparam logic [31:0] SEED = 32'd77103;
  // 7 directed + 200 random + 100 stalled + 10 occupancy + 5 lost in reset + 2 after
  localparam int TOTAL_REQS     = 324;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 300 * 2 + 200;

  // resp_rdy modes
  localparam logic [1:0] RDY_HIGH   = 2'd0;
  localparam logic [1:0] RDY_LOW    = 2'd1;
  localparam logic [1:0] RDY_RANDOM = 2'd2;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          req_val;
  wire                           req_rdy;
  logic [gcd_pkg::REQ_WIDTH-1:0] req_msg;
  wire                           resp_val;
  logic                          resp_rdy;
  wire gcd_pkg::operand_t        resp_msg;

  gcd_top dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  always #20 clk = ~clk;

  // -------------------------------------------------------------------
  // shared state
  // -------------------------------------------------------------------

  logic [gcd_pkg::REQ_WIDTH-1:0] stim_q[$];
  logic [gcd_pkg::REQ_WIDTH-1:0] op_q[$];
  gcd_pkg::operand_t             exp_q[$];
  logic [31:0]                   rng_ops = SEED;
  logic [31:0]                   rng_rdy = SEED ^ 32'h9e37_79b9;
  logic [1:0]                    rdy_mode = RDY_HIGH;
  logic                          saw_full = 1'b0;
  int unsigned                   errors = 0;
  int unsigned                   cycles = 0;
  int unsigned                   tests_ok = 0;
  int unsigned                   tests_bad = 0;
  int unsigned                   start;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Euclid by remainder where a zero operand gives the other one
  function automatic int unsigned ref_gcd(input int unsigned a, input int unsigned b);
    int unsigned x;
    int unsigned y;
    int unsigned t;
    x = a;
    y = b;
    while (y != 0) begin
      t = x % y;
      x = y;
      y = t;
    end
    return x;
  endfunction

  function automatic int unsigned fails_now();
    return errors + dut.props.error_count;
  endfunction

  // -------------------------------------------------------------------
  // response side with consumer ready and scoreboard
  // -------------------------------------------------------------------

  always @(posedge clk) begin
    rng_rdy = xorshift(rng_rdy);
    case (rdy_mode)
      RDY_LOW:    resp_rdy <= 1'b0;
      RDY_RANDOM: resp_rdy <= rng_rdy[4];
      default:    resp_rdy <= 1'b1;
    endcase
  end

  always @(posedge clk) begin : monitor
    gcd_pkg::operand_t             want;
    logic [gcd_pkg::REQ_WIDTH-1:0] ops;
    if (!reset) begin
      // expected value queued at the request transfer
      if (req_val && req_rdy) begin
        op_q.push_back(req_msg);
        exp_q.push_back(gcd_pkg::operand_t'(ref_gcd(req_msg[31:16], req_msg[15:0])));
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response %0d at %0t with no request outstanding",
                   resp_msg, $time);
          errors++;
        end else begin
          want = exp_q.pop_front();
          ops  = op_q.pop_front();
          assert (resp_msg == want) else begin
            $display("Fail at %0t: gcd(%0d, %0d) expected %0d, got %0d",
                     $time, ops[31:16], ops[15:0], want, resp_msg);
            errors++;
          end
        end
      end
      if (!req_rdy) begin
        saw_full = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d responses still missing", cycles, exp_q.size());
      $display("Testbench failed");
      $finish;
    end
  end

  // -------------------------------------------------------------------
  // stimulus helpers
  // -------------------------------------------------------------------

  task automatic push_pair(input int unsigned a, input int unsigned b);
    stim_q.push_back({gcd_pkg::operand_t'(a), gcd_pkg::operand_t'(b)});
  endtask

  // mask limits operand size and so the compute time
  task automatic fill_random(input int count, input logic [7:0] mask);
    logic [7:0] a;
    logic [7:0] b;
    repeat (count) begin
      rng_ops = xorshift(rng_ops);
      a = rng_ops[7:0] & mask;
      rng_ops = xorshift(rng_ops);
      b = rng_ops[7:0] & mask;
      push_pair(a, b);
    end
  endtask

  // called right after a rising edge and holds each request until taken
  task automatic send_all();
    logic [gcd_pkg::REQ_WIDTH-1:0] msg;
    while (stim_q.size() != 0) begin
      msg = stim_q.pop_front();
      req_val <= 1'b1;
      req_msg <= msg;
      @(posedge clk);
      while (!req_rdy) @(posedge clk);
    end
    req_val <= 1'b0;
  endtask

  // waits for all answers and then a quiet window for stray responses
  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int unsigned first);
    if (fails_now() == first) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d error(s)", name, fails_now() - first);
      tests_bad++;
    end
  endtask

  // -------------------------------------------------------------------
  // test sequence
  // -------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // directed pairs including zero operands
    @(negedge clk);
    start = fails_now();
    push_pair(15, 10);
    push_pair(22, 10);
    push_pair(36, 18);
    push_pair(36, 21);
    push_pair(0, 7);
    push_pair(9, 0);
    push_pair(0, 0);
    @(posedge clk);
    send_all();
    wait_drain();
    report_test("directed values", start);

    start = fails_now();
    fill_random(200, 8'hff);
    @(posedge clk);
    send_all();
    wait_drain();
    report_test("random operands", start);

    start = fails_now();
    fill_random(100, 8'hff);
    @(posedge clk);
    rdy_mode <= RDY_RANDOM;
    send_all();
    wait_drain();
    @(posedge clk);
    rdy_mode <= RDY_HIGH;
    report_test("random back-pressure", start);

    // tiny operands so the unit fills both queues inside the stall
    @(negedge clk);
    start    = fails_now();
    saw_full = 1'b0;
    fill_random(10, 8'h03);
    @(posedge clk);
    rdy_mode <= RDY_LOW;
    fork
      send_all();
      begin
        repeat (40) @(posedge clk);
        @(negedge clk);
        assert (saw_full) else begin
          $display("req_rdy never fell during the 40-cycle response stall");
          errors++;
        end
        @(posedge clk);
        rdy_mode <= RDY_HIGH;
      end
    join
    wait_drain();
    report_test("occupancy bound", start);

    // second reset with stalled work in both queues and the unit
    @(negedge clk);
    start = fails_now();
    push_pair(30, 12);
    push_pair(21, 14);
    push_pair(9, 6);
    push_pair(40, 25);
    push_pair(27, 18);
    @(posedge clk);
    rdy_mode <= RDY_LOW;
    send_all();
    @(posedge clk);
    while (!resp_val) @(posedge clk);
    reset    <= 1'b1;
    rdy_mode <= RDY_HIGH;
    // stalled answers are lost with the reset
    exp_q.delete();
    op_q.delete();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);
    push_pair(48, 18);
    push_pair(7, 13);
    send_all();
    wait_drain();
    report_test("reset state", start);

    $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && fails_now() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- gcd_accel.f
logic/gcd_pkg.sv
logic/msg_queue.sv
logic/gcd_ctrl.sv
logic/gcd_dpath.sv
logic/gcd_top.sv
test/gcd_top_properties.sv
test/gcd_top_tb.sv
